//--- build.f
+incdir+bench
verilog/lsu_pkg.sv
verilog/lsu_store_lanes.sv
verilog/lsu_load_format.sv
verilog/lsu_ctrl.sv
verilog/lsu_top.sv
bench/lsu_tb.sv

//--- Makefile
# Verilator build and run of the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) --binary --timing --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST) $(VFLAGS)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '*** PASSED ***' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/lsu_tb_model.svh
// reference model: bus and model memories, LCG, expected lanes, store merge, load extension

localparam logic [31:0] BASE_ADDR = 32'h0000_2000;   // 64-word window starts here

logic [31:0]                lcg_state = 32'd39;      // fixed seed
logic [lsu_pkg::DATA_W-1:0] bus_mem   [0:63];        // served by the responder
logic [lsu_pkg::DATA_W-1:0] model_mem [0:63];        // expected contents

// upper LCG bits, the low ones cycle too fast
function automatic logic [15:0] rand16();
   lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
   return lcg_state[30:15];
endfunction

// every word of the window gets a different value
function automatic logic [31:0] fill_word(input logic [31:0] addr);
   return (addr * 32'h9E37_79B1) ^ 32'h5AC3_3CA5;
endfunction

task automatic init_memories();
   logic [31:0] a;
   for (int i = 0; i < 64; i++)
   begin
      a = BASE_ADDR + {24'd0, 6'(i), 2'b00};
      bus_mem[i]   = fill_word(a);
      model_mem[i] = fill_word(a);
   end
endtask

function automatic logic is_store_op(input lsu_pkg::lsu_op_e op);
   return (op == lsu_pkg::SB) || (op == lsu_pkg::SH) || (op == lsu_pkg::SW);
endfunction

function automatic logic exp_misalign(input lsu_pkg::lsu_op_e op, input logic [1:0] off);
   case (op)
      lsu_pkg::LWZ, lsu_pkg::SW: return off != 2'b00;
      lsu_pkg::LHZ, lsu_pkg::LHS, lsu_pkg::SH: return off[0];
      default: return 1'b0;   // bytes fit anywhere
   endcase
endfunction

// big endian, offset 0 is lane 3
function automatic logic [lsu_pkg::BSEL_W-1:0] exp_bsel(input lsu_pkg::lsu_op_e op,
                                                        input logic [1:0] off);
   case (op)
      lsu_pkg::LBZ, lsu_pkg::LBS, lsu_pkg::SB: return 4'b1000 >> off;
      lsu_pkg::LHZ, lsu_pkg::LHS, lsu_pkg::SH: return 4'b1100 >> off;
      default: return 4'b1111;
   endcase
endfunction

function automatic logic [31:0] exp_wdata(input lsu_pkg::lsu_op_e op, input logic [31:0] d);
   case (op)
      lsu_pkg::LBZ, lsu_pkg::LBS, lsu_pkg::SB: return {d[7:0], d[7:0], d[7:0], d[7:0]};
      lsu_pkg::LHZ, lsu_pkg::LHS, lsu_pkg::SH: return {d[15:0], d[15:0]};
      default: return d;
   endcase
endfunction

// only selected lanes change
function automatic logic [31:0] merge_store(input logic [31:0] old_w, input logic [31:0] wdat,
                                            input logic [lsu_pkg::BSEL_W-1:0] bsel);
   logic [31:0] merged;
   merged = old_w;
   for (int i = 0; i < lsu_pkg::BSEL_W; i++)
      if (bsel[i])
         merged[8*i +: 8] = wdat[8*i +: 8];
   return merged;
endfunction

// pick the addressed byte or half out of the word, then extend
function automatic logic [31:0] exp_load(input lsu_pkg::lsu_op_e op, input logic [1:0] off,
                                         input logic [31:0] word);
   logic [7:0]  b;
   logic [15:0] h;
   b = 8'(word >> (5'd24 - {off, 3'b000}));
   h = 16'(word >> (5'd16 - {off, 3'b000}));   // off is 0 or 2 here
   case (op)
      lsu_pkg::LBZ: return {24'd0, b};
      lsu_pkg::LBS: return {{24{b[7]}}, b};
      lsu_pkg::LHZ: return {16'd0, h};
      lsu_pkg::LHS: return {{16{h[15]}}, h};
      default:      return word;
   endcase
endfunction

//--- bench/lsu_tb.sv
// lsu_tb: testbench top with clock, reset, random commands, bus responder and compare tasks
`timescale 1ns/1ps

module lsu_tb;

   localparam logic [7:0] WD_LIMIT = 8'd8;   // watchdog limit for the DUT
   localparam int NUM_CMDS    = 400;
   localparam int CMD_TIMEOUT = 40;          // cycles per command before giving up

   logic                             clk;
   logic                             rst;
   logic                             cmd_valid;
   lsu_pkg::lsu_op_e                 cmd_op;
   logic [lsu_pkg::DATA_W-1:0]       cmd_addr;
   logic [lsu_pkg::DATA_W-1:0]       cmd_data;
   logic                             busy;
   logic                             done;
   logic [lsu_pkg::DATA_W-1:0]       result;
   logic                             except_align;
   logic                             except_bus;
   logic [lsu_pkg::DATA_W-1:0]       dbus_adr;
   logic                             dbus_req;
   logic                             dbus_we;
   logic [lsu_pkg::BSEL_W-1:0]       dbus_bsel;
   logic [lsu_pkg::DATA_W-1:0]       dbus_wdat;
   logic                             dbus_ack;
   logic                             dbus_err;
   logic [lsu_pkg::DATA_W-1:0]       dbus_rdat;
   int                               accepted = 0;     // commands handed to the DUT
   int                               done_count = 0;   // done pulses seen

   `include "lsu_tb_model.svh"

   lsu_top #(
      .TIMEOUT_CYCLES (WD_LIMIT)
   ) u_dut (
      .clk            (clk),
      .rst            (rst),
      .cmd_valid_i    (cmd_valid),
      .cmd_op_i       (cmd_op),
      .cmd_addr_i     (cmd_addr),
      .cmd_data_i     (cmd_data),
      .busy_o         (busy),
      .done_o         (done),
      .result_o       (result),
      .except_align_o (except_align),
      .except_bus_o   (except_bus),
      .dbus_adr_o     (dbus_adr),
      .dbus_req_o     (dbus_req),
      .dbus_we_o      (dbus_we),
      .dbus_bsel_o    (dbus_bsel),
      .dbus_dat_o     (dbus_wdat),
      .dbus_ack_i     (dbus_ack),
      .dbus_err_i     (dbus_err),
      .dbus_dat_i     (dbus_rdat)
   );

   always #2 clk = ~clk;   // 4 ns period

   // mid-cycle count of completion pulses
   always @(negedge clk)
      if (!rst && done)
         done_count++;

   task automatic fail_stop(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input string name, input logic [lsu_pkg::DATA_W-1:0] exp_v,
                             input logic [lsu_pkg::DATA_W-1:0] act_v);
      if (act_v !== exp_v)
         fail_stop($sformatf("[FAIL] %s expected %h actual %h", name, exp_v, act_v));
   endtask

   task automatic check_bsel(input string name, input logic [lsu_pkg::BSEL_W-1:0] exp_v,
                             input logic [lsu_pkg::BSEL_W-1:0] act_v);
      if (act_v !== exp_v)
         fail_stop($sformatf("[FAIL] %s expected %b actual %b", name, exp_v, act_v));
   endtask

   task automatic check_flag(input string name, input logic exp_v, input logic act_v);
      if (act_v !== exp_v)
         fail_stop($sformatf("[FAIL] %s expected %b actual %b", name, exp_v, act_v));
   endtask

   // outputs settle at the edge, inputs change half a ns later
   task automatic next_cycle();
      @(posedge clk);
      #0.5;
   endtask

   // one command from valid to done, acting as bus responder on the way
   task automatic run_command(input int n);
      lsu_pkg::lsu_op_e op;
      logic [15:0]      r;
      logic [5:0]       idx;
      logic [1:0]       off;
      logic [1:0]       wait_n;                // wait cycles before the answer
      logic [31:0]      addr;
      logic [31:0]      data;
      logic             give_err;
      logic             silent;
      logic             mis;
      logic             responded;
      logic             finished;
      int               cycles;
      int               req_cnt;
      string            tag;
      r        = rand16();
      op       = lsu_pkg::lsu_op_e'(r[2:0]);
      off      = r[4:3];
      idx      = r[10:5];
      wait_n   = r[12:11];
      r        = rand16();
      give_err = (r[3:0] == 4'd0);             // about 1 in 16
      silent   = (r[8:4] == 5'd0);             // about 1 in 32, wins over err
      data     = {rand16(), rand16()};
      addr     = BASE_ADDR + {24'd0, idx, off};
      mis      = exp_misalign(op, off);
      tag      = $sformatf("cmd %0d %s @%h", n, op.name(), addr);
      cmd_valid = 1'b1;                        // accepted on the first edge with busy low
      cmd_op    = op;
      cmd_addr  = addr;
      cmd_data  = data;
      cycles    = 0;
      while (busy)                             // held through the done cycle of the last one
      begin
         cycles++;
         if (cycles > CMD_TIMEOUT)
            fail_stop({tag, ": timeout, busy never dropped for the next command"});
         next_cycle();
      end
      next_cycle();
      accepted++;
      cycles    = 0;
      req_cnt   = 0;
      responded = 1'b0;
      finished  = 1'b0;
      while (!finished)
      begin
         dbus_ack  = 1'b0;
         dbus_err  = 1'b0;
         dbus_rdat = {rand16(), rand16()};     // junk unless acked
         if (done)
         begin
            cmd_valid = 1'b0;
            check_flag({tag, " busy in done"}, 1'b1, busy);
            if (mis && cycles != 1)
               fail_stop({tag, ": misaligned done not two cycles after acceptance"});
            if (!mis && !silent && !responded)
               fail_stop({tag, ": done came without a bus response"});
            if (!mis && silent && req_cnt != int'(WD_LIMIT))
               fail_stop($sformatf("%s: watchdog ended after %0d req cycles", tag, req_cnt));
            check_flag({tag, " align flag"}, mis, except_align);
            check_flag({tag, " bus flag"}, !mis && (silent || give_err), except_bus);
            if (!mis && !silent && !give_err)
            begin
               if (is_store_op(op))
                  model_mem[idx] = merge_store(model_mem[idx], exp_wdata(op, data),
                                               exp_bsel(op, off));
               else
                  check_word({tag, " result"}, exp_load(op, off, model_mem[idx]), result);
            end
            finished = 1'b1;
         end
         else
         begin
            check_flag({tag, " busy"}, 1'b1, busy);
            if (responded)
               fail_stop({tag, ": no done in the cycle after the response"});
            // level from the cycle after acceptance, never for a misaligned access
            check_flag({tag, " req"}, !mis, dbus_req);
            if (dbus_req)
            begin
               req_cnt++;
               if (req_cnt > int'(WD_LIMIT))
                  fail_stop({tag, ": req still high after the watchdog limit"});
               check_word({tag, " adr"}, addr, dbus_adr);
               check_bsel({tag, " bsel"}, exp_bsel(op, off), dbus_bsel);
               check_word({tag, " wdat"}, exp_wdata(op, data), dbus_wdat);
               check_flag({tag, " we"}, is_store_op(op), dbus_we);
               if (!silent && req_cnt == int'(wait_n) + 1)
               begin
                  responded = 1'b1;
                  if (give_err)
                     dbus_err = 1'b1;
                  else
                  begin
                     dbus_ack = 1'b1;
                     if (dbus_we)   // slave side write with the DUT's own lanes
                        bus_mem[dbus_adr[7:2]] = merge_store(bus_mem[dbus_adr[7:2]],
                                                             dbus_wdat, dbus_bsel);
                     else
                        dbus_rdat = bus_mem[dbus_adr[7:2]];
                  end
               end
            end
            // stray valid pulses while busy must be ignored
            r         = rand16();
            cmd_valid = r[0] & r[1];
            cmd_op    = lsu_pkg::lsu_op_e'(r[4:2]);
            cmd_addr  = {rand16(), rand16()};
            cycles++;
            if (cycles > CMD_TIMEOUT)
               fail_stop({tag, ": timeout, no done pulse after acceptance"});
            next_cycle();
         end
      end
   endtask

   initial
   begin
      logic [15:0] gap;
      clk       = 1'b0;
      rst       = 1'b1;
      cmd_valid = 1'b0;
      cmd_op    = lsu_pkg::LBZ;
      cmd_addr  = '0;
      cmd_data  = '0;
      dbus_ack  = 1'b0;
      dbus_err  = 1'b0;
      dbus_rdat = '0;
      init_memories();
      repeat (10) next_cycle();
      rst = 1'b0;
      check_flag("reset req", 1'b0, dbus_req);
      check_flag("reset done", 1'b0, done);
      check_flag("reset busy", 1'b0, busy);
      check_flag("reset align flag", 1'b0, except_align);
      check_flag("reset bus flag", 1'b0, except_bus);
      for (int n = 0; n < NUM_CMDS; n++)
      begin
         run_command(n);
         gap = rand16();
         if (gap[1:0] == 2'd0)
            next_cycle();   // otherwise next command shows up in the done cycle
      end
      next_cycle();         // counter sees the last done at the negedge
      if (done_count != accepted)
         fail_stop($sformatf("%0d done pulses for %0d accepted commands",
                             done_count, accepted));
      else
      begin
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule

//--- verilog/lsu_top.sv
// lsu_top: load/store unit top level, control FSM plus store lane and load format datapaths
`timescale 1ns/1ps

module lsu_top #(
   parameter logic [7:0] TIMEOUT_CYCLES = 8'd16   // watchdog limit in request cycles
) (
   input  logic                          clk,
   input  logic                          rst,
   // command
   input  logic                          cmd_valid_i,
   input  lsu_pkg::lsu_op_e              cmd_op_i,
   input  logic [lsu_pkg::DATA_W-1:0]    cmd_addr_i,
   input  logic [lsu_pkg::DATA_W-1:0]    cmd_data_i,
   // completion
   output logic                          busy_o,
   output logic                          done_o,
   output logic [lsu_pkg::DATA_W-1:0]    result_o,
   output logic                          except_align_o,
   output logic                          except_bus_o,
   // data bus
   output logic [lsu_pkg::DATA_W-1:0]    dbus_adr_o,
   output logic                          dbus_req_o,
   output logic                          dbus_we_o,
   output logic [lsu_pkg::BSEL_W-1:0]    dbus_bsel_o,
   output logic [lsu_pkg::DATA_W-1:0]    dbus_dat_o,
   input  logic                          dbus_ack_i,
   input  logic                          dbus_err_i,
   input  logic [lsu_pkg::DATA_W-1:0]    dbus_dat_i
);

   lsu_pkg::lsu_op_e             op;            // registered opcode
   logic [lsu_pkg::DATA_W-1:0]   store_data;
   logic                         misalign;
   logic                         capture;

   // registered address goes straight out as the bus address
   lsu_ctrl #(
      .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
   ) u_ctrl (
      .clk            (clk),
      .rst            (rst),
      .cmd_valid_i    (cmd_valid_i),
      .cmd_op_i       (cmd_op_i),
      .cmd_addr_i     (cmd_addr_i),
      .cmd_data_i     (cmd_data_i),
      .misalign_i     (misalign),
      .dbus_ack_i     (dbus_ack_i),
      .dbus_err_i     (dbus_err_i),
      .op_o           (op),
      .addr_o         (dbus_adr_o),
      .store_data_o   (store_data),
      .dbus_req_o     (dbus_req_o),
      .dbus_we_o      (dbus_we_o),
      .capture_o      (capture),
      .busy_o         (busy_o),
      .done_o         (done_o),
      .except_align_o (except_align_o),
      .except_bus_o   (except_bus_o)
   );

   // only the byte offset matters for lanes
   lsu_store_lanes u_store_lanes (
      .op_i           (op),
      .addr_i         (dbus_adr_o[1:0]),
      .store_data_i   (store_data),
      .bsel_o         (dbus_bsel_o),
      .wdata_o        (dbus_dat_o),
      .misalign_o     (misalign)
   );

   lsu_load_format u_load_format (
      .clk            (clk),
      .op_i           (op),
      .addr_i         (dbus_adr_o[1:0]),
      .rdata_i        (dbus_dat_i),
      .capture_i      (capture),
      .result_o       (result_o)
   );

endmodule

//--- verilog/lsu_ctrl.sv
// lsu_ctrl: command register, IDLE/REQ/DONE FSM, bus watchdog, completion and flag outputs
`timescale 1ns/1ps

module lsu_ctrl #(
   parameter logic [7:0] TIMEOUT_CYCLES = 8'd16   // request cycles before bus error
) (
   input  logic                          clk,
   input  logic                          rst,
   // command side
   input  logic                          cmd_valid_i,
   input  lsu_pkg::lsu_op_e              cmd_op_i,
   input  logic [lsu_pkg::DATA_W-1:0]    cmd_addr_i,
   input  logic [lsu_pkg::DATA_W-1:0]    cmd_data_i,
   // from store lanes
   input  logic                          misalign_i,
   // bus response
   input  logic                          dbus_ack_i,
   input  logic                          dbus_err_i,
   // registered command to the datapath
   output lsu_pkg::lsu_op_e              op_o,
   output logic [lsu_pkg::DATA_W-1:0]    addr_o,
   output logic [lsu_pkg::DATA_W-1:0]    store_data_o,
   // bus control
   output logic                          dbus_req_o,
   output logic                          dbus_we_o,
   // to load format
   output logic                          capture_o,
   // status and completion
   output logic                          busy_o,
   output logic                          done_o,
   output logic                          except_align_o,
   output logic                          except_bus_o
);

   lsu_pkg::lsu_state_e             state_q;
   lsu_pkg::lsu_state_e             state_d;
   lsu_pkg::lsu_op_e                op_q;         // registered command
   logic [lsu_pkg::DATA_W-1:0]      addr_q;
   logic [lsu_pkg::DATA_W-1:0]      data_q;
   logic [7:0]                      wd_cnt_q;     // request cycles seen so far
   logic                            except_align_q;
   logic                            except_bus_q;
   logic                            accept;
   logic                            in_req;
   logic                            timeout;
   logic                            resp;
   logic                            is_store;

   assign busy_o  = (state_q != lsu_pkg::IDLE);
   assign accept  = cmd_valid_i & ~busy_o;       // only back-pressure is busy
   assign in_req  = (state_q == lsu_pkg::REQ);
   assign timeout = (wd_cnt_q == TIMEOUT_CYCLES - 8'd1);   // last allowed req cycle
   assign resp    = dbus_ack_i | dbus_err_i | timeout;

   // stores write, loads read
   assign is_store = (op_q == lsu_pkg::SB) | (op_q == lsu_pkg::SH) | (op_q == lsu_pkg::SW);

   // next state
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         lsu_pkg::IDLE:
            if (accept)
               state_d = lsu_pkg::REQ;
         lsu_pkg::REQ:
            if (misalign_i | resp)   // fault, response or watchdog all end the access
               state_d = lsu_pkg::DONE;
         lsu_pkg::DONE:
            state_d = lsu_pkg::IDLE;
         default:
            state_d = lsu_pkg::IDLE;
      endcase
   end

   // state, watchdog and flags
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state_q        <= lsu_pkg::IDLE;
         wd_cnt_q       <= 8'd0;
         except_align_q <= 1'b0;
         except_bus_q   <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (accept)
            wd_cnt_q <= 8'd0;                 // fresh count per command
         else if (dbus_req_o)
            wd_cnt_q <= wd_cnt_q + 8'd1;
         // flags only live in the done cycle
         except_align_q <= in_req & misalign_i;
         // ack on the last cycle still counts as success
         except_bus_q   <= dbus_req_o & (dbus_err_i | (timeout & ~dbus_ack_i));
      end
   end

   // command capture on acceptance
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         op_q   <= cmd_op_i;
         addr_q <= cmd_addr_i;
         data_q <= cmd_data_i;
      end
   end

   assign op_o         = op_q;
   assign addr_o       = addr_q;
   assign store_data_o = data_q;

   // misaligned access never reaches the bus
   assign dbus_req_o = in_req & ~misalign_i;
   assign dbus_we_o  = is_store;

   // latch read data on a clean load ack
   assign capture_o = dbus_req_o & dbus_ack_i & ~dbus_err_i & ~is_store;

   assign done_o         = (state_q == lsu_pkg::DONE);
   assign except_align_o = except_align_q;
   assign except_bus_o   = except_bus_q;

endmodule

//--- verilog/lsu_load_format.sv
// lsu_load_format: read data lane alignment, zero/sign extension, result register
`timescale 1ns/1ps

module lsu_load_format (
   input  logic                          clk,
   input  lsu_pkg::lsu_op_e              op_i,
   input  logic [1:0]                    addr_i,      // byte offset in the word
   input  logic [lsu_pkg::DATA_W-1:0]    rdata_i,
   input  logic                          capture_i,
   output logic [lsu_pkg::DATA_W-1:0]    result_o
);

   logic [lsu_pkg::DATA_W-1:0] aligned;
   logic [lsu_pkg::DATA_W-1:0] extended;
   logic [lsu_pkg::DATA_W-1:0] result_q;

   // move the addressed byte up to bits 31:24
   assign aligned = rdata_i << {addr_i, 3'b000};

   // extension per opcode, data now sits in the top bits
   always_comb
   begin
      case (op_i)
         lsu_pkg::LBZ:
            extended = {{(lsu_pkg::DATA_W-8){1'b0}}, aligned[lsu_pkg::DATA_W-1 -: 8]};
         lsu_pkg::LBS:
            extended = {{(lsu_pkg::DATA_W-8){aligned[lsu_pkg::DATA_W-1]}},
                        aligned[lsu_pkg::DATA_W-1 -: 8]};
         lsu_pkg::LHZ:
            extended = {{(lsu_pkg::DATA_W-16){1'b0}}, aligned[lsu_pkg::DATA_W-1 -: 16]};
         lsu_pkg::LHS:
            extended = {{(lsu_pkg::DATA_W-16){aligned[lsu_pkg::DATA_W-1]}},
                        aligned[lsu_pkg::DATA_W-1 -: 16]};
         default:
            extended = aligned;   // word load, offset is 0 here
      endcase
   end

   // hold through the done cycle
   always_ff @(posedge clk)
   begin
      if (capture_i)
         result_q <= extended;
   end

   assign result_o = result_q;

endmodule

//--- verilog/lsu_store_lanes.sv
// lsu_store_lanes: big-endian byte selects, store data replication, alignment check
`timescale 1ns/1ps

module lsu_store_lanes (
   input  lsu_pkg::lsu_op_e              op_i,
   input  logic [1:0]                    addr_i,        // byte offset in the word
   input  logic [lsu_pkg::DATA_W-1:0]    store_data_i,
   output logic [lsu_pkg::BSEL_W-1:0]    bsel_o,
   output logic [lsu_pkg::DATA_W-1:0]    wdata_o,
   output logic                          misalign_o
);

   logic is_byte;
   logic is_half;
   logic is_word;

   // access size from the opcode
   always_comb
   begin
      is_byte = 1'b0;
      is_half = 1'b0;
      is_word = 1'b0;
      case (op_i)
         lsu_pkg::LBZ, lsu_pkg::LBS, lsu_pkg::SB: is_byte = 1'b1;
         lsu_pkg::LHZ, lsu_pkg::LHS, lsu_pkg::SH: is_half = 1'b1;
         default:                                 is_word = 1'b1;   // LWZ, SW
      endcase
   end

   // offset 0 is the msb lane
   always_comb
   begin
      if (is_byte)
      begin
         case (addr_i)
            2'b00:   bsel_o = 4'b1000;
            2'b01:   bsel_o = 4'b0100;
            2'b10:   bsel_o = 4'b0010;
            default: bsel_o = 4'b0001;
         endcase
      end
      else if (is_half)
         bsel_o = addr_i[1] ? 4'b0011 : 4'b1100;   // upper or lower half
      else
         bsel_o = 4'b1111;
   end

   // replicate so every lane carries the operand
   always_comb
   begin
      if (is_byte)
         wdata_o = {4{store_data_i[7:0]}};
      else if (is_half)
         wdata_o = {2{store_data_i[15:0]}};
      else
         wdata_o = store_data_i;
   end

   // word needs both low bits clear, halfword needs bit 0 clear
   assign misalign_o = (is_word & (|addr_i)) | (is_half & addr_i[0]);

endmodule

//--- verilog/lsu_pkg.sv
// lsu_pkg: opcode enum, control state enum, data and byte-select widths
package lsu_pkg;

   // data path and address width, one word
   localparam int DATA_W = 32;

   // one select line per byte lane, bit 3 is the top (msb) lane
   localparam int BSEL_W = 4;

   // load/store operations
   // loads first, bit order keeps stores at the top of the code space
   typedef enum logic [2:0] {
      LBZ = 3'd0,    // load byte, zero extend
      LBS = 3'd1,    // load byte, sign extend
      LHZ = 3'd2,    // load halfword, zero extend
      LHS = 3'd3,    // load halfword, sign extend
      LWZ = 3'd4,    // load word
      SB  = 3'd5,    // store byte
      SH  = 3'd6,    // store halfword
      SW  = 3'd7     // store word
   } lsu_op_e;

   // control FSM states
   typedef enum logic [1:0] {
      IDLE = 2'd0,   // waiting for a command
      REQ  = 2'd1,   // bus request or alignment fault
      DONE = 2'd2    // one-cycle completion
   } lsu_state_e;

endpackage
